/* verilog.f */
hdl/sw_egr_pkg.sv
hdl/egr_tdest_remap.sv
hdl/egr_switch.sv
hdl/sw_egr_top.sv
dv/sw_egr_checker.sv
dv/sw_egr_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := sw_egr_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/sw_egr_tb.sv */
`timescale 1ns/10ps

module sw_egr_tb;
    import sw_egr_pkg::*;

    localparam int NUM_PKT         = 8;
    localparam int MAX_LEN         = 4;
    localparam int NUM_TEST        = 4;
    localparam int WATCHDOG_CYCLES = NUM_TEST * NUM_PKT * MAX_LEN * NUM_IN * 20;

    logic         core_clk;
    logic         arst_n;
    axis_beat_t   src_beat     [NUM_IN];
    logic         src_valid    [NUM_IN];
    logic         src_ready    [NUM_IN];
    axis_beat_t   out_beat     [NUM_OUT];
    logic         out_valid    [NUM_OUT];
    logic         out_ready    [NUM_OUT];
    remap_table_t tbl0;
    remap_table_t tbl1;

    logic [31:0]  lfsr = 32'hebf6_8d02;
    int           cyc = 0;
    bit           rand_ready;
    port_t        target;       // common output of the same_output test
    string        cur_test;
    logic [7:0]   seq_no       [NUM_IN];
    int           last_in_cyc  [NUM_IN];
    int           last_out_cyc [NUM_OUT];
    port_t        exp_port     [NUM_IN][256];
    axis_beat_t   exp_q        [NUM_IN*NUM_OUT][$];   // indexed by src * NUM_OUT + output

    sw_egr_top dut0 (
        .core_clk    (core_clk),
        .arst_n      (arst_n),
        .app0_beat   (src_beat[0]),
        .app0_valid  (src_valid[0]),
        .app0_ready  (src_ready[0]),
        .app1_beat   (src_beat[1]),
        .app1_valid  (src_valid[1]),
        .app1_ready  (src_ready[1]),
        .byp_beat    (src_beat[2]),
        .byp_valid   (src_valid[2]),
        .byp_ready   (src_ready[2]),
        .remap_tbl0  (tbl0),
        .remap_tbl1  (tbl1),
        .cmac0_beat  (out_beat[0]),
        .cmac0_valid (out_valid[0]),
        .cmac0_ready (out_ready[0]),
        .cmac1_beat  (out_beat[1]),
        .cmac1_valid (out_valid[1]),
        .cmac1_ready (out_ready[1]),
        .host0_beat  (out_beat[2]),
        .host0_valid (out_valid[2]),
        .host0_ready (out_ready[2]),
        .host1_beat  (out_beat[3]),
        .host1_valid (out_valid[3]),
        .host1_ready (out_ready[3])
    );

    initial begin
        core_clk = 1'b0;
        forever #4 core_clk = ~core_clk;
    end

    always @(posedge core_clk) cyc <= cyc + 1;

    // ****************************************
    // helpers
    // ****************************************
    // taps 32, 22, 2, 1 and one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic compare_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_port(input string name, input port_t exp, input port_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("Fail %s: expected %0d actual %0d", name, exp, act));
        end
    endtask

    // loopback picks tid and any other destination indexes the table with its low two bits
    function automatic port_t model_port(input int src, input axis_beat_t b);
        logic [1:0] sel;
        sel = (b.tdest.raw == 3'd4) ? b.tid : b.tdest.raw[1:0];
        if (src == 2) begin
            return port_t'(b.tdest.raw[1:0]);    // bypass is never remapped
        end
        return (src == 0) ? tbl0[sel] : tbl1[sel];
    endfunction

    task automatic randomize_tables();
        for (int k = 0; k < 4; k++) begin
            tbl0[k] = port_t'(2'(take_bits(2)));
            tbl1[k] = port_t'(2'(take_bits(2)));
        end
    endtask

    task automatic fill_tables(input port_t p);
        for (int k = 0; k < 4; k++) begin
            tbl0[k] = p;
            tbl1[k] = p;
        end
    endtask

    // ****************************************
    // stimulus and model
    // ****************************************
    task automatic send_packets(input int src, input int npkt, input int max_len, input bit same);
        axis_beat_t beat;
        axis_beat_t exp;
        port_t      port;
        int         len;
        logic [2:0] r;
        @(posedge core_clk);
        #1;
        for (int p = 0; p < npkt; p++) begin
            if (take_bits(1) == 1) begin
                src_valid[src] = 1'b0;
                @(posedge core_clk);
                #1;
            end
            len        = int'(take_bits(2)) % max_len + 1;
            r          = 3'(take_bits(3));
            beat       = '0;
            beat.tid   = port_t'(2'(take_bits(2)));
            beat.tuser = smartnic_meta_t'(13'(take_bits(13)));
            if (src == 2) begin
                beat.tdest.raw = same ? {1'b0, target} : {1'b0, r[1:0]};
            end else begin
                beat.tdest.raw = (r > 3'd4) ? 3'd4 : r;   // loopback gets the spare codes
            end
            port = model_port(src, beat);
            exp_port[src][seq_no[src]] = port;
            for (int b = 0; b < len; b++) begin
                beat.tdata    = {8'(src), seq_no[src], 24'(take_bits(24)), 24'(take_bits(24))};
                beat.tkeep    = 8'(take_bits(8));
                beat.tlast    = (b == len - 1);
                exp           = beat;
                exp.tdest.raw = {1'b0, port};
                if (port < HOST_PORT0) begin
                    exp.tuser = '0;
                end
                exp_q[src*NUM_OUT + int'(port)].push_back(exp);
                src_beat[src]  = beat;
                src_valid[src] = 1'b1;
                do @(negedge core_clk); while (!src_ready[src]);
                last_in_cyc[src] = cyc + 1;
                @(posedge core_clk);
                #1;
            end
            seq_no[src]++;
        end
        src_valid[src] = 1'b0;
    endtask

    task automatic wait_drained();
        bit busy;
        do begin
            @(negedge core_clk);
            busy = 1'b0;
            for (int q = 0; q < NUM_IN*NUM_OUT; q++) begin
                if (exp_q[q].size() != 0) busy = 1'b1;
            end
        end while (busy);
        repeat (4) @(posedge core_clk);
        #1;
    endtask

    task automatic run_traffic(input bit same);
        fork
            send_packets(0, NUM_PKT, MAX_LEN, same);
            send_packets(1, NUM_PKT, MAX_LEN, same);
            send_packets(2, NUM_PKT, MAX_LEN, same);
        join
        wait_drained();
    endtask

    initial begin
        forever begin
            @(posedge core_clk);
            #1;
            for (int o = 0; o < NUM_OUT; o++) begin
                out_ready[o] = rand_ready ? 1'(take_bits(1)) : 1'b1;
            end
        end
    end

    // ****************************************
    // scoreboard, one monitor per output
    // ****************************************
    for (genvar o = 0; o < NUM_OUT; o++) begin : g_mon
        initial begin
            int         src;
            bit         in_pkt;
            axis_beat_t exp;
            src    = 0;
            in_pkt = 1'b0;
            forever begin
                @(negedge core_clk);
                if (out_valid[o] && out_ready[o]) begin
                    last_out_cyc[o] = cyc + 1;
                    if (!in_pkt) begin
                        src = int'(out_beat[o].tdata[63:56]);   // source byte picks the queue
                        if (src >= NUM_IN) begin
                            abort_run($sformatf("output %0d carried an unknown source byte", o));
                        end
                        compare_port($sformatf("%s output of src%0d packet %0d", cur_test, src,
                                               out_beat[o].tdata[55:48]),
                                     exp_port[src][out_beat[o].tdata[55:48]], port_t'(o));
                    end
                    if (exp_q[src*NUM_OUT + o].size() == 0) begin
                        abort_run($sformatf("output %0d delivered a beat nobody sent", o));
                    end
                    exp = exp_q[src*NUM_OUT + o].pop_front();
                    compare_beat($sformatf("%s src%0d beat on output %0d", cur_test, src, o),
                                 exp, out_beat[o]);
                    in_pkt = !out_beat[o].tlast;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge core_clk);
        abort_run($sformatf("watchdog expired after %0d cycles, traffic still pending",
                            WATCHDOG_CYCLES));
    end

    initial begin
        arst_n     = 1'b0;
        rand_ready = 1'b0;
        target     = CMAC_PORT0;
        cur_test   = "reset";
        tbl0       = '0;
        tbl1       = '0;
        for (int i = 0; i < NUM_IN; i++) begin
            src_beat[i]  = '0;
            src_valid[i] = 1'b0;
            seq_no[i]    = '0;
        end
        for (int o = 0; o < NUM_OUT; o++) begin
            out_ready[o] = 1'b1;
        end
        repeat (5) @(posedge core_clk);
        #1;
        arst_n = 1'b1;

        cur_test = "remap_rule";        // also covers loopback and bypass routing
        randomize_tables();
        run_traffic(1'b0);

        cur_test = "same_output";
        target   = port_t'(2'(take_bits(2)));
        fill_tables(target);
        run_traffic(1'b1);

        cur_test   = "backpressure";
        randomize_tables();
        rand_ready = 1'b1;
        run_traffic(1'b0);
        rand_ready = 1'b0;
        wait_drained();

        cur_test = "idle_latency";
        target   = HOST_PORT0;
        fill_tables(target);
        send_packets(0, 1, 1, 1'b1);
        wait_drained();
        compare_count("idle_latency app0", 2, last_out_cyc[HOST_PORT0] - last_in_cyc[0]);
        send_packets(2, 1, 1, 1'b1);
        wait_drained();
        compare_count("idle_latency bypass", 1, last_out_cyc[HOST_PORT0] - last_in_cyc[2]);

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* dv/sw_egr_checker.sv */
`timescale 1ns/10ps

module sw_egr_checker (
    input logic                   core_clk,
    input logic                   arst_n,
    input sw_egr_pkg::axis_beat_t cmac0_beat,
    input logic                   cmac0_valid,
    input logic                   cmac0_ready,
    input sw_egr_pkg::axis_beat_t cmac1_beat,
    input logic                   cmac1_valid,
    input logic                   cmac1_ready,
    input sw_egr_pkg::axis_beat_t host0_beat,
    input logic                   host0_valid,
    input logic                   host0_ready,
    input sw_egr_pkg::axis_beat_t host1_beat,
    input logic                   host1_valid,
    input logic                   host1_ready
);
    import sw_egr_pkg::*;

    axis_beat_t beat  [NUM_OUT];
    logic       valid [NUM_OUT];
    logic       ready [NUM_OUT];

    assign beat[0]  = cmac0_beat;
    assign beat[1]  = cmac1_beat;
    assign beat[2]  = host0_beat;
    assign beat[3]  = host1_beat;
    assign valid[0] = cmac0_valid;
    assign valid[1] = cmac1_valid;
    assign valid[2] = host0_valid;
    assign valid[3] = host1_valid;
    assign ready[0] = cmac0_ready;
    assign ready[1] = cmac1_ready;
    assign ready[2] = host0_ready;
    assign ready[3] = host1_ready;

    for (genvar o = 0; o < NUM_OUT; o++) begin : g_chk
        // a stalled beat has to wait unchanged for its sink
        a_stable: assert property (@(posedge core_clk) disable iff (!arst_n)
            valid[o] && !ready[o] |=> valid[o] && $stable(beat[o]))
            else $error("output %0d changed a stalled beat", o);

        a_valid_known: assert property (@(posedge core_clk) disable iff (!arst_n)
            !$isunknown(valid[o]))
            else $error("output %0d valid is unknown", o);

        a_beat_known: assert property (@(posedge core_clk) disable iff (!arst_n)
            valid[o] |-> !$isunknown(beat[o]))
            else $error("output %0d presents an unknown beat", o);

        a_reset_idle: assert property (@(posedge core_clk) !arst_n |-> !valid[o])
            else $error("output %0d is valid during reset", o);
    end

endmodule

bind sw_egr_top sw_egr_checker chk0 (
    .core_clk    (core_clk),
    .arst_n      (arst_n),
    .cmac0_beat  (cmac0_beat),
    .cmac0_valid (cmac0_valid),
    .cmac0_ready (cmac0_ready),
    .cmac1_beat  (cmac1_beat),
    .cmac1_valid (cmac1_valid),
    .cmac1_ready (cmac1_ready),
    .host0_beat  (host0_beat),
    .host0_valid (host0_valid),
    .host0_ready (host0_ready),
    .host1_beat  (host1_beat),
    .host1_valid (host1_valid),
    .host1_ready (host1_ready)
);

/* hdl/sw_egr_top.sv */
`timescale 1ns/10ps

module sw_egr_top (
    input  logic                     core_clk,
    input  logic                     arst_n,

    input  sw_egr_pkg::axis_beat_t   app0_beat,
    input  logic                     app0_valid,
    output logic                     app0_ready,
    input  sw_egr_pkg::axis_beat_t   app1_beat,
    input  logic                     app1_valid,
    output logic                     app1_ready,
    input  sw_egr_pkg::axis_beat_t   byp_beat,
    input  logic                     byp_valid,
    output logic                     byp_ready,

    input  sw_egr_pkg::remap_table_t remap_tbl0,
    input  sw_egr_pkg::remap_table_t remap_tbl1,

    output sw_egr_pkg::axis_beat_t   cmac0_beat,
    output logic                     cmac0_valid,
    input  logic                     cmac0_ready,
    output sw_egr_pkg::axis_beat_t   cmac1_beat,
    output logic                     cmac1_valid,
    input  logic                     cmac1_ready,
    output sw_egr_pkg::axis_beat_t   host0_beat,
    output logic                     host0_valid,
    input  logic                     host0_ready,
    output sw_egr_pkg::axis_beat_t   host1_beat,
    output logic                     host1_valid,
    input  logic                     host1_ready
);
    import sw_egr_pkg::*;

    // switch side, sources in the order app0, app1, bypass
    axis_beat_t sw_s_beat  [NUM_IN];
    logic       sw_s_valid [NUM_IN];
    logic       sw_s_ready [NUM_IN];
    axis_beat_t sw_m_beat  [NUM_OUT];
    logic       sw_m_valid [NUM_OUT];
    logic       sw_m_ready [NUM_OUT];

    // ****************************************
    // tdest remap, one per app stream
    // ****************************************
    egr_tdest_remap remap0 (
        .core_clk  (core_clk),
        .arst_n    (arst_n),
        .s_beat    (app0_beat),
        .s_valid   (app0_valid),
        .s_ready   (app0_ready),
        .remap_tbl (remap_tbl0),
        .m_beat    (sw_s_beat[0]),
        .m_valid   (sw_s_valid[0]),
        .m_ready   (sw_s_ready[0])
    );

    egr_tdest_remap remap1 (
        .core_clk  (core_clk),
        .arst_n    (arst_n),
        .s_beat    (app1_beat),
        .s_valid   (app1_valid),
        .s_ready   (app1_ready),
        .remap_tbl (remap_tbl1),
        .m_beat    (sw_s_beat[1]),
        .m_valid   (sw_s_valid[1]),
        .m_ready   (sw_s_ready[1])
    );

    // bypass is already addressed by real port code
    assign sw_s_beat[2]  = byp_beat;
    assign sw_s_valid[2] = byp_valid;
    assign byp_ready     = sw_s_ready[2];

    egr_switch switch0 (
        .core_clk (core_clk),
        .arst_n   (arst_n),
        .s_beat   (sw_s_beat),
        .s_valid  (sw_s_valid),
        .s_ready  (sw_s_ready),
        .m_beat   (sw_m_beat),
        .m_valid  (sw_m_valid),
        .m_ready  (sw_m_ready)
    );

    // ****************************************
    // outputs
    // ****************************************
    assign cmac0_beat  = sw_m_beat[CMAC_PORT0];
    assign cmac0_valid = sw_m_valid[CMAC_PORT0];
    assign cmac1_beat  = sw_m_beat[CMAC_PORT1];
    assign cmac1_valid = sw_m_valid[CMAC_PORT1];
    assign host0_beat  = sw_m_beat[HOST_PORT0];
    assign host0_valid = sw_m_valid[HOST_PORT0];
    assign host1_beat  = sw_m_beat[HOST_PORT1];
    assign host1_valid = sw_m_valid[HOST_PORT1];

    assign sw_m_ready[CMAC_PORT0] = cmac0_ready;
    assign sw_m_ready[CMAC_PORT1] = cmac1_ready;
    assign sw_m_ready[HOST_PORT0] = host0_ready;
    assign sw_m_ready[HOST_PORT1] = host1_ready;

endmodule

/* hdl/egr_switch.sv */
`timescale 1ns/10ps

module egr_switch (
    input  logic                   core_clk,
    input  logic                   arst_n,

    input  sw_egr_pkg::axis_beat_t s_beat  [sw_egr_pkg::NUM_IN],
    input  logic                   s_valid [sw_egr_pkg::NUM_IN],
    output logic                   s_ready [sw_egr_pkg::NUM_IN],

    output sw_egr_pkg::axis_beat_t m_beat  [sw_egr_pkg::NUM_OUT],
    output logic                   m_valid [sw_egr_pkg::NUM_OUT],
    input  logic                   m_ready [sw_egr_pkg::NUM_OUT]
);
    import sw_egr_pkg::*;

    logic       src_sop   [NUM_IN];   // head beat of each source opens a packet
    logic       src_xfer  [NUM_IN];
    logic       sel_valid [NUM_OUT];
    logic [1:0] sel_src   [NUM_OUT];
    logic       out_free  [NUM_OUT];

    // returns {found, index}, searching upward from the source after last
    function automatic logic [2:0] rr_pick(input logic [NUM_IN-1:0] r,
                                           input logic [1:0]        last);
        logic [2:0] pick;
        int         idx;
        pick = {1'b0, last};
        // walk from the far end so the nearest requester is written last
        for (int k = NUM_IN; k >= 1; k--) begin
            idx = (int'(last) + k) % NUM_IN;
            if (r[idx]) begin
                pick = {1'b1, 2'(idx)};
            end
        end
        return pick;
    endfunction

    // ****************************************
    // per source
    // ****************************************
    for (genvar i = 0; i < NUM_IN; i++) begin : g_src

        // a source is never selected by two outputs in the same cycle
        always_comb begin
            s_ready[i] = 1'b0;
            for (int o = 0; o < NUM_OUT; o++) begin
                if (sel_valid[o] && sel_src[o] == 2'(i) && out_free[o]) begin
                    s_ready[i] = 1'b1;
                end
            end
        end

        assign src_xfer[i] = s_valid[i] && s_ready[i];

        always_ff @(posedge core_clk or negedge arst_n) begin
            if (!arst_n) begin
                src_sop[i] <= 1'b1;
            end else if (src_xfer[i]) begin
                src_sop[i] <= s_beat[i].tlast;
            end
        end

    end

    // ****************************************
    // per output
    // ****************************************
    for (genvar o = 0; o < NUM_OUT; o++) begin : g_out

        localparam bit IS_HOST = (o >= int'(HOST_PORT0));

        logic [NUM_IN-1:0] req;
        logic [2:0]        pick;
        logic              locked;     // a packet is in flight on this output
        logic [1:0]        last_gnt;   // also the owner while locked
        logic              out_xfer;
        axis_beat_t        sel_beat;
        axis_beat_t        shaped;

        // only packet heads aimed at this output may ask for it
        always_comb begin
            for (int i = 0; i < NUM_IN; i++) begin
                req[i] = s_valid[i] && src_sop[i] && (s_beat[i].tdest.raw[1:0] == 2'(o));
            end
        end

        assign pick         = rr_pick(req, last_gnt);
        assign sel_valid[o] = locked || pick[2];
        assign sel_src[o]   = locked ? last_gnt : pick[1:0];
        assign sel_beat     = s_beat[sel_src[o]];

        assign out_free[o] = !m_valid[o] || m_ready[o];
        assign out_xfer    = sel_valid[o] && s_valid[sel_src[o]] && out_free[o];

        always_comb begin
            shaped           = sel_beat;
            shaped.tdest.raw = {1'b0, 2'(o)};
            if (!IS_HOST) begin
                shaped.tuser = '0;     // rss metadata only goes to the host
            end
        end

        always_ff @(posedge core_clk or negedge arst_n) begin
            if (!arst_n) begin
                locked     <= 1'b0;
                last_gnt   <= 2'(NUM_IN - 1);   // first search starts at app0
                m_valid[o] <= 1'b0;
            end else begin
                if (out_xfer) begin
                    locked   <= !sel_beat.tlast;
                    last_gnt <= sel_src[o];
                end
                if (out_free[o]) begin
                    m_valid[o] <= out_xfer;
                end
            end
        end

        always_ff @(posedge core_clk) begin
            if (out_xfer) begin
                m_beat[o] <= shaped;
            end
        end

    end

endmodule

/* hdl/egr_tdest_remap.sv */
`timescale 1ns/10ps

module egr_tdest_remap (
    input  logic                     core_clk,
    input  logic                     arst_n,

    input  sw_egr_pkg::axis_beat_t   s_beat,
    input  logic                     s_valid,
    output logic                     s_ready,

    input  sw_egr_pkg::remap_table_t remap_tbl,

    output sw_egr_pkg::axis_beat_t   m_beat,
    output logic                     m_valid,
    input  logic                     m_ready
);
    import sw_egr_pkg::*;

    logic       s_xfer;
    logic       in_sop;     // next accepted beat opens a packet
    port_t      sel_port;
    port_t      sop_port;
    port_t      pkt_port;
    port_t      cur_port;
    axis_beat_t stamped;

    // the stage holds a single beat and frees up as soon as its output is taken
    assign s_ready = !m_valid || m_ready;
    assign s_xfer  = s_valid && s_ready;

    // ****************************************
    // destination decode
    // ****************************************
    // loopback sends the packet back out towards the port it came in on
    always_comb begin
        if (s_beat.tdest.dest == LOOPBACK) begin
            sel_port = s_beat.tid;
        end else begin
            sel_port = port_t'(s_beat.tdest.raw[1:0]);
        end
    end

    assign sop_port = remap_tbl[sel_port];

    // later beats reuse the port decided at the head of the packet
    assign cur_port = in_sop ? sop_port : pkt_port;

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            in_sop <= 1'b1;
        end else if (s_xfer) begin
            in_sop <= s_beat.tlast;
        end
    end

    always_ff @(posedge core_clk) begin
        if (s_xfer && in_sop) begin
            pkt_port <= sop_port;   // table is sampled only once per packet
        end
    end

    // ****************************************
    // output register
    // ****************************************
    always_comb begin
        stamped           = s_beat;
        stamped.tdest.raw = {1'b0, cur_port};
    end

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid <= 1'b0;
        end else if (s_ready) begin
            m_valid <= s_valid;
        end
    end

    always_ff @(posedge core_clk) begin
        if (s_xfer) begin
            m_beat <= stamped;
        end
    end

endmodule

/* hdl/sw_egr_pkg.sv */
package sw_egr_pkg;

    // ****************************************
    // sizes
    // ****************************************
    localparam int DATA_BYTES = 8;
    localparam int NUM_OUT    = 4;  // cmac0, cmac1, host0, host1
    localparam int NUM_IN     = 3;  // app0, app1, bypass

    // ****************************************
    // port and destination encodings
    // ****************************************
    typedef enum logic [1:0] {
        CMAC_PORT0 = 2'd0,
        CMAC_PORT1 = 2'd1,
        HOST_PORT0 = 2'd2,
        HOST_PORT1 = 2'd3
    } port_t;

    // same codes as port_t with the loopback request added on top
    typedef enum logic [2:0] {
        EGR_CMAC_PORT0 = 3'd0,
        EGR_CMAC_PORT1 = 3'd1,
        EGR_HOST_PORT0 = 3'd2,
        EGR_HOST_PORT1 = 3'd3,
        LOOPBACK       = 3'd4
    } egr_dest_e;

    typedef union packed {
        egr_dest_e  dest;
        logic [2:0] raw;
    } egr_tdest_u;

    typedef struct packed {
        logic        rss_enable;
        logic [11:0] rss_entropy;
    } smartnic_meta_t;

    typedef struct packed {
        logic [DATA_BYTES*8-1:0] tdata;
        logic [DATA_BYTES-1:0]   tkeep;
        logic                    tlast;
        port_t                   tid;    // ingress port of the packet
        egr_tdest_u              tdest;
        smartnic_meta_t          tuser;
    } axis_beat_t;

    // indexed by the selected port code
    typedef port_t [3:0] remap_table_t;

endpackage
